/* Bender.yml */
package:
  name: vid_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/vid_pkg.sv
      - logic/vid_regs.sv
      - timing/vid_timing.sv
      - fetch/vid_fetch.sv
      - logic/pixel_fifo.sv
      - logic/pixel_out.sv
      - logic/vid_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/vid_bus_model.sv
      - sim/vid_tb.sv

/* common/vid_config.svh */
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// Bus command codes
`define VID_CMD_IDLE       3'b000
`define VID_CMD_DATA       3'b001
`define VID_CMD_READ       3'b010
`define VID_CMD_DATA_LAST  3'b011
`define VID_CMD_WRITE      3'b100

// Register byte offsets
`define VID_ADDR_CTRL      32'h0000_0000
`define VID_ADDR_H1        32'h0000_0028
`define VID_ADDR_H2        32'h0000_0030
`define VID_ADDR_V1        32'h0000_0038
`define VID_ADDR_V2        32'h0000_0040
`define VID_ADDR_BASE      32'h0000_0048
`define VID_ADDR_STRIDE    32'h0000_0050

`define VID_CTRL_EN        3              // Enable bit in ctrl
`define VID_CTRL_PCNT      9:4            // Pixel divider in ctrl
`define VID_FLD_LO         12:0           // Total or sync end
`define VID_FLD_HI         25:13          // Visible or sync start

`define VID_TWIDTH         13
`define VID_PCNT_WIDTH     6
`define VID_BURST_LEN      4              // Beats per read burst
`define VID_BURST_CODE     2'b10          // Length code for four beats
`define VID_FIFO_DEPTH     8

`endif

/* common/vid_pkg.sv */
`include "vid_config.svh"

package vid_pkg;

    typedef struct packed {
        logic [7:0] r;                    // Bits 23:16 of a beat
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [2:0]  cmd;
        logic [31:0] addrdata;
    } host_bus_t;

    typedef struct packed {
        logic [2:0]  cmd;
        logic [1:0]  len;
        logic [31:0] addrdata;
    } mem_req_t;

    typedef struct packed {
        logic                       en;
        logic [`VID_PCNT_WIDTH-1:0] pcnt;
        logic [`VID_TWIDTH-1:0]     hend;
        logic [`VID_TWIDTH-1:0]     hsize;
        logic [`VID_TWIDTH-1:0]     hsync_start;
        logic [`VID_TWIDTH-1:0]     hsync_end;
        logic [`VID_TWIDTH-1:0]     vend;
        logic [`VID_TWIDTH-1:0]     vsize;
        logic [`VID_TWIDTH-1:0]     vsync_start;
        logic [`VID_TWIDTH-1:0]     vsync_end;
        logic [31:0]                base;
        logic [31:0]                stride;
    } vid_cfg_t;

    typedef struct packed {
        logic hsync;
        logic hblank;
        logic vsync;
        logic vblank;
    } sync_t;

    typedef struct packed {
        logic                   start;
        logic [`VID_TWIDTH-1:0] line;     // Index of the line to fetch
    } line_req_t;

    // Levels while idle or disabled
    localparam sync_t SYNC_IDLE = '{hsync: 1'b0, hblank: 1'b1, vsync: 1'b0, vblank: 1'b1};

endpackage

/* fetch/vid_fetch.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_fetch (
    input  logic                               clk,
    input  logic                               reset_n,
    input  vid_pkg::vid_cfg_t                  cfg,
    input  vid_pkg::line_req_t                 line_req,
    input  vid_pkg::host_bus_t                 mem_rsp,
    output vid_pkg::mem_req_t                  mem_req,
    output logic                               push,
    output vid_pkg::rgb_t                      push_data,
    input  logic [$clog2(`VID_FIFO_DEPTH):0]   level
);

    typedef enum logic [1:0] {F_IDLE, F_WAIT, F_ROOM} fetch_state_e;

    fetch_state_e           state;
    logic                   pend;         // Line request seen mid-burst
    logic [`VID_TWIDTH-1:0] pend_line;
    logic [`VID_TWIDTH-1:0] left;         // Pixels still to push for this line
    logic [`VID_TWIDTH-1:0] left_nxt;
    logic [`VID_TWIDTH-1:0] new_line;
    logic [31:0]            line_addr;
    logic [31:0]            burst_addr;   // Address of the next burst
    logic [31:0]            issue_addr;
    logic                   beat, last, keep, room, new_req;
    logic                   start_line, next_burst, issue;

    assign beat       = (state == F_WAIT) &&
                        (mem_rsp.cmd == `VID_CMD_DATA || mem_rsp.cmd == `VID_CMD_DATA_LAST);
    assign last       = (state == F_WAIT) && (mem_rsp.cmd == `VID_CMD_DATA_LAST);
    assign new_req    = line_req.start || pend;
    assign keep       = cfg.en && beat && (left != '0) && !new_req;
    assign left_nxt   = keep ? left - 1'b1 : left;
    assign room       = (level + push) <= (`VID_FIFO_DEPTH - `VID_BURST_LEN);
    assign new_line   = line_req.start ? line_req.line : pend_line;
    assign line_addr  = cfg.base + new_line * cfg.stride;
    assign start_line = cfg.en && new_req && ((state != F_WAIT) || last);
    assign next_burst = cfg.en && !new_req && (state == F_ROOM) && room;
    assign issue      = start_line || next_burst;
    assign issue_addr = start_line ? line_addr : burst_addr;

    always_ff @(posedge clk) begin
        if (issue) begin
            burst_addr <= issue_addr + (`VID_BURST_LEN * 4);
        end
        if (line_req.start) begin
            pend_line <= line_req.line;
        end
        push_data <= mem_rsp.addrdata[23:0];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= F_IDLE;
            pend    <= 1'b0;
            left    <= '0;
            push    <= 1'b0;
            mem_req <= '0;
        end else begin
            push    <= keep;
            mem_req <= issue ? '{cmd: `VID_CMD_READ, len: `VID_BURST_CODE, addrdata: issue_addr}
                             : '0;
            if (!cfg.en) begin
                state <= F_IDLE;
                pend  <= 1'b0;
                left  <= '0;
            end else if (start_line) begin
                state <= F_WAIT;
                pend  <= 1'b0;
                left  <= cfg.hsize;
            end else if (next_burst) begin
                state <= F_WAIT;
            end else if (line_req.start) begin
                pend <= 1'b1;                 // Finish the old burst first
                left <= '0;
            end else begin
                left <= left_nxt;
                if (last) begin
                    state <= (left_nxt != '0) ? F_ROOM : F_IDLE;
                end
            end
        end
    end

    // Room check before each burst keeps the FIFO from overflowing
    a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
        push |-> (level != `VID_FIFO_DEPTH));

endmodule

/* flist.f */
+incdir+common
common/vid_pkg.sv
logic/vid_regs.sv
timing/vid_timing.sv
fetch/vid_fetch.sv
logic/pixel_fifo.sv
logic/pixel_out.sv
logic/vid_top.sv
sim/vid_bus_model.sv
sim/vid_tb.sv

/* logic/pixel_fifo.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module pixel_fifo (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             flush,
    input  logic                             push,
    input  logic                             pop,
    input  vid_pkg::rgb_t                    push_data,
    output vid_pkg::rgb_t                    pop_data,
    output logic [$clog2(`VID_FIFO_DEPTH):0] level,
    output logic                             empty
);

    import vid_pkg::*;

    localparam int AW = $clog2(`VID_FIFO_DEPTH);

    rgb_t        mem [`VID_FIFO_DEPTH];
    logic [AW:0] wr_ptr;                  // Top bit is the wrap flag
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_push;
    logic        do_pop;

    assign level    = wr_ptr - rd_ptr;
    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_push  = push && !full && !flush;
    assign do_pop   = pop && !empty && !flush;
    assign pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                     // Empty in one clock
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // The output stage must check empty before popping
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        pop |-> !empty);

endmodule

/* logic/pixel_out.sv */
`timescale 1ns/1ps

module pixel_out (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           pix_en,
    input  vid_pkg::sync_t sync_in,
    input  vid_pkg::rgb_t  pop_data,
    input  logic           empty,
    output logic           pop,
    output vid_pkg::sync_t sync_out,
    output vid_pkg::rgb_t  rgb,
    output logic           underrun
);

    import vid_pkg::*;

    logic active;

    assign active = !sync_in.hblank && !sync_in.vblank;
    assign pop    = pix_en && active && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_out <= SYNC_IDLE;
            rgb      <= '0;
            underrun <= 1'b0;
        end else begin
            sync_out <= sync_in;              // Same delay as the pixel
            if (!active) begin
                rgb <= '0;
            end else if (pix_en) begin
                rgb <= empty ? '0 : pop_data; // Black when starved
            end
            if (pix_en && active && empty) begin
                underrun <= 1'b1;             // Sticky until reset
            end
        end
    end

endmodule

/* logic/vid_regs.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  vid_pkg::host_bus_t  host,
    output vid_pkg::vid_cfg_t   cfg
);

    logic        wr_pend;                 // WRITE seen last cycle
    logic [31:0] wr_addr;                 // Offset from the WRITE cycle
    logic        wr_data;

    assign wr_data = wr_pend && (host.cmd == `VID_CMD_DATA);

    always_ff @(posedge clk) begin
        if (host.cmd == `VID_CMD_WRITE) begin
            wr_addr <= host.addrdata;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_pend <= 1'b0;
            cfg     <= '0;
        end else begin
            wr_pend <= (host.cmd == `VID_CMD_WRITE);
            if (wr_data) begin
                if (wr_addr == `VID_ADDR_CTRL) begin
                    cfg.en   <= host.addrdata[`VID_CTRL_EN];
                    cfg.pcnt <= host.addrdata[`VID_CTRL_PCNT];
                end else if (!cfg.en) begin   // Timing and framebuffer locked while enabled
                    case (wr_addr)
                        `VID_ADDR_H1: begin
                            cfg.hend  <= host.addrdata[`VID_FLD_LO];
                            cfg.hsize <= host.addrdata[`VID_FLD_HI];
                        end
                        `VID_ADDR_H2: begin
                            cfg.hsync_end   <= host.addrdata[`VID_FLD_LO];
                            cfg.hsync_start <= host.addrdata[`VID_FLD_HI];
                        end
                        `VID_ADDR_V1: begin
                            cfg.vend  <= host.addrdata[`VID_FLD_LO];
                            cfg.vsize <= host.addrdata[`VID_FLD_HI];
                        end
                        `VID_ADDR_V2: begin
                            cfg.vsync_end   <= host.addrdata[`VID_FLD_LO];
                            cfg.vsync_start <= host.addrdata[`VID_FLD_HI];
                        end
                        `VID_ADDR_BASE: begin
                            cfg.base <= host.addrdata;
                        end
                        `VID_ADDR_STRIDE: begin
                            cfg.stride <= host.addrdata;
                        end
                        default: ;                    // Unmapped offset
                    endcase
                end
            end
        end
    end

endmodule

/* logic/vid_top.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_top (
    input  logic               clk,
    input  logic               reset_n,
    input  vid_pkg::host_bus_t host,
    input  vid_pkg::host_bus_t mem_rsp,
    output vid_pkg::mem_req_t  mem_req,
    output vid_pkg::sync_t     sync,
    output vid_pkg::rgb_t      rgb,
    output logic               underrun
);

    import vid_pkg::*;

    vid_cfg_t                         cfg;
    logic                             pix_en;
    sync_t                            tsync;    // Syncs before the output stage
    line_req_t                        line_req;
    logic                             flush;
    logic                             push;
    logic                             pop;
    logic                             empty;
    rgb_t                             push_data;
    rgb_t                             pop_data;
    logic [$clog2(`VID_FIFO_DEPTH):0] level;

    vid_regs u_regs (
        .clk     (clk),
        .reset_n (reset_n),
        .host    (host),
        .cfg     (cfg)
    );

    vid_timing u_timing (
        .clk      (clk),
        .reset_n  (reset_n),
        .cfg      (cfg),
        .pix_en   (pix_en),
        .sync     (tsync),
        .line_req (line_req),
        .flush    (flush)
    );

    vid_fetch u_fetch (
        .clk       (clk),
        .reset_n   (reset_n),
        .cfg       (cfg),
        .line_req  (line_req),
        .mem_rsp   (mem_rsp),
        .mem_req   (mem_req),
        .push      (push),
        .push_data (push_data),
        .level     (level)
    );

    pixel_fifo u_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .flush     (flush),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .pop_data  (pop_data),
        .level     (level),
        .empty     (empty)
    );

    pixel_out u_out (
        .clk      (clk),
        .reset_n  (reset_n),
        .pix_en   (pix_en),
        .sync_in  (tsync),
        .pop_data (pop_data),
        .empty    (empty),
        .pop      (pop),
        .sync_out (sync),
        .rgb      (rgb),
        .underrun (underrun)
    );

endmodule

/* sim/vid_bus_model.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_bus_model #(
    parameter logic [31:0] SEED       = 32'h1,
    parameter int          LONG_DELAY = 40
) (
    input  logic               clk,
    input  logic               reset_n,
    input  vid_pkg::mem_req_t  req,
    input  logic               long_delay,       // Starve the FIFO
    output vid_pkg::host_bus_t rsp
);

    import vid_pkg::*;

    initial begin
        logic [31:0] addr;
        int          delay;
        rsp = '{cmd: `VID_CMD_IDLE, addrdata: '0};
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            rsp = '{cmd: `VID_CMD_IDLE, addrdata: '0};
            if (reset_n && req.cmd == `VID_CMD_READ) begin
                addr  = req.addrdata;
                delay = 1 + ($urandom % 3);
                if (long_delay) begin
                    delay = delay + LONG_DELAY;
                end
                repeat (delay - 1) @(negedge clk);
                for (int i = 0; i < `VID_BURST_LEN; i++) begin
                    @(negedge clk);
                    rsp.cmd      = (i == `VID_BURST_LEN - 1) ? `VID_CMD_DATA_LAST : `VID_CMD_DATA;
                    rsp.addrdata = {8'h00, addr[23:0]};   // Pixel equals its own address
                    addr         = addr + 32'd4;
                end
            end
        end
    end

endmodule

/* sim/vid_tb.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_tb;

    import vid_pkg::*;

    localparam int WD_CYCLES = 3 * 240 + 2 * 240 + 6 * 450 + 1000;   // Frames of both configs

    logic clk, reset_n, long_delay;
    host_bus_t host, mem_rsp;
    mem_req_t  mem_req;
    sync_t     vid_sync;
    rgb_t      rgb;
    logic      underrun;
    logic      idle_chk, run_chk, strict;
    int        mism_cnt, fail_cnt;
    int        t_pcnt, t_hsize, t_hss, t_hse, t_vsize, t_vss, t_vse;
    logic [31:0] t_base, t_stride;
    int        cyc, ycnt, hs_cnt, vs_lines, rd_k, rd_y, div;
    logic      prev_hb;
    logic      framed;                    // A visible line was seen since enable

    vid_top UUT (.clk(clk), .reset_n(reset_n), .host(host), .mem_rsp(mem_rsp),
                 .mem_req(mem_req), .sync(vid_sync), .rgb(rgb), .underrun(underrun));

    vid_bus_model #(.SEED(32'h4e6b_ba4d)) framebuffer (.clk(clk), .reset_n(reset_n),
        .req(mem_req), .long_delay(long_delay), .rsp(mem_rsp));

    function automatic logic [23:0] pixel_at(int x, int y);
        logic [31:0] a;
        a = t_base + y * t_stride + 4 * x;
        return a[23:0];
    endfunction

    function automatic logic [31:0] burst_addr(int k, int y);
        return t_base + y * t_stride + 16 * k;
    endfunction

    task automatic host_write(logic [31:0] addr, logic [31:0] value);
        @(negedge clk);
        host = '{cmd: `VID_CMD_WRITE, addrdata: addr};
        @(negedge clk);
        host = '{cmd: `VID_CMD_DATA, addrdata: value};
        @(negedge clk);
        host = '{cmd: `VID_CMD_IDLE, addrdata: '0};
    endtask

    task automatic program_timing(int hend, int vend);
        host_write(`VID_ADDR_H1, (t_hsize << 13) | hend);
        host_write(`VID_ADDR_H2, (t_hss << 13) | t_hse);
        host_write(`VID_ADDR_V1, (t_vsize << 13) | vend);
        host_write(`VID_ADDR_V2, (t_vss << 13) | t_vse);
        host_write(`VID_ADDR_BASE, t_base);
        host_write(`VID_ADDR_STRIDE, t_stride);
    endtask

    task automatic wait_frames(int n);
        repeat (n) @(posedge vid_sync.vblank);
    endtask

    assign div = t_pcnt + 1;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Output-side position counters, updated from the values before each edge
    always @(posedge clk) begin
        if (!run_chk) begin
            cyc      <= 0;
            ycnt     <= 0;
            hs_cnt   <= 0;
            vs_lines <= 0;
            rd_k     <= 0;
            rd_y     <= 0;
            prev_hb  <= 1'b1;
            framed   <= 1'b0;
        end else begin
            prev_hb <= vid_sync.hblank;
            cyc     <= vid_sync.hblank ? 0 : cyc + 1;
            hs_cnt  <= vid_sync.hsync ? hs_cnt + 1 : 0;
            if (!vid_sync.vblank)
                framed <= 1'b1;
            if (vid_sync.vblank)
                ycnt <= 0;
            else if (!vid_sync.hblank && cyc == t_hsize * div - 1)
                ycnt <= ycnt + 1;
            if (!vid_sync.vsync)
                vs_lines <= 0;
            else if (vid_sync.hblank && !prev_hb)
                vs_lines <= vs_lines + 1;
            if (mem_req.cmd == `VID_CMD_READ) begin
                if (rd_k == (t_hsize + 3) / 4 - 1) begin
                    rd_k <= 0;
                    rd_y <= (rd_y + 1 == t_vsize) ? 0 : rd_y + 1;
                end else begin
                    rd_k <= rd_k + 1;
                end
            end
        end
    end

    a_idle: assert property (@(posedge clk) idle_chk |->
        (vid_sync == SYNC_IDLE && rgb == '0 && mem_req.cmd == `VID_CMD_IDLE && !underrun))
        else begin
            fail_cnt++;
            $display("Outputs left their idle values while disabled");
        end
    a_hblank_w: assert property (@(posedge clk) run_chk && $rose(vid_sync.hblank) |->
        cyc == t_hsize * div)
        else begin
            mism_cnt++;
            $display("MISMATCH hblank_width exp=%0d act=%0d", t_hsize * div, $sampled(cyc));
        end
    a_hsync_w: assert property (@(posedge clk) run_chk && $fell(vid_sync.hsync) |->
        hs_cnt == (t_hse - t_hss) * div)
        else begin
            mism_cnt++;
            $display("MISMATCH hsync_width exp=%0d act=%0d",
                (t_hse - t_hss) * div, $sampled(hs_cnt));
        end
    a_vblank_w: assert property (@(posedge clk) run_chk && $rose(vid_sync.vblank) |->
        ycnt == t_vsize)
        else begin
            mism_cnt++;
            $display("MISMATCH vblank_lines exp=%0d act=%0d", t_vsize, $sampled(ycnt));
        end
    // The pulse in the partial frame right after enable is not counted
    a_vsync_w: assert property (@(posedge clk) run_chk && framed && $fell(vid_sync.vsync) |->
        vs_lines == t_vse - t_vss)
        else begin
            mism_cnt++;
            $display("MISMATCH vsync_lines exp=%0d act=%0d",
                t_vse - t_vss, $sampled(vs_lines));
        end
    a_read: assert property (@(posedge clk) strict && mem_req.cmd == `VID_CMD_READ |->
        mem_req.len == `VID_BURST_CODE && mem_req.addrdata == burst_addr(rd_k, rd_y))
        else begin
            mism_cnt++;
            $display("MISMATCH read_addr exp=%h act=%h",
                burst_addr($sampled(rd_k), $sampled(rd_y)), $sampled(mem_req.addrdata));
        end
    a_pixel: assert property (@(posedge clk) strict && !vid_sync.hblank && !vid_sync.vblank |->
        rgb == pixel_at(cyc / div, ycnt))
        else begin
            mism_cnt++;
            $display("MISMATCH pixel exp=%h act=%h",
                pixel_at($sampled(cyc) / div, $sampled(ycnt)), $sampled(rgb));
        end
    a_blank_black: assert property (@(posedge clk) run_chk &&
        (vid_sync.hblank || vid_sync.vblank) |-> rgb == '0)
        else begin
            mism_cnt++;
            $display("MISMATCH blank_rgb exp=000000 act=%h", $sampled(rgb));
        end
    a_starved: assert property (@(posedge clk) $rose(underrun) |-> rgb == '0)
        else begin
            mism_cnt++;
            $display("MISMATCH underrun_rgb exp=000000 act=%h", $sampled(rgb));
        end

    initial begin
        #(WD_CYCLES * 10);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int waited;
        host       = '{cmd: `VID_CMD_IDLE, addrdata: '0};
        reset_n    = 1'b0;
        long_delay = 1'b0;
        idle_chk   = 1'b0;
        run_chk    = 1'b0;
        strict     = 1'b0;
        mism_cnt   = 0;
        fail_cnt   = 0;
        t_pcnt     = 1;
        t_hsize    = 8;
        t_hss      = 10;
        t_hse      = 14;
        t_vsize    = 3;
        t_vss      = 3;
        t_vse      = 4;
        t_base     = 32'h0012_3400;
        t_stride   = 32'h0000_0040;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        idle_chk = 1'b1;
        program_timing(24, 5);
        repeat (4) @(negedge clk);
        idle_chk = 1'b0;
        run_chk  = 1'b1;
        strict   = 1'b1;
        host_write(`VID_ADDR_CTRL, (t_pcnt << 4) | 32'h8);
        wait_frames(3);
        host_write(`VID_ADDR_H1, (4 << 13) | 20);     // Locked while enabled
        wait_frames(2);
        run_chk = 1'b0;
        strict  = 1'b0;
        host_write(`VID_ADDR_CTRL, 32'h0);
        repeat (4) @(negedge clk);
        idle_chk = 1'b1;
        t_pcnt  = 2;
        t_hsize = 12;
        t_hss   = 14;
        t_hse   = 20;
        t_vss   = 3;
        t_vse   = 5;
        program_timing(30, 5);
        idle_chk = 1'b0;
        run_chk  = 1'b1;
        strict   = 1'b1;
        host_write(`VID_ADDR_CTRL, (t_pcnt << 4) | 32'h8);
        wait_frames(3);
        strict = 1'b0;
        long_delay = 1'b1;
        waited = 0;
        while (!underrun && waited < 3 * 450) begin
            @(negedge clk);
            waited++;
        end
        if (!underrun) begin
            fail_cnt++;
            $display("Underrun flag never rose with the slow framebuffer");
        end
        $display("Checks done: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* timing/vid_timing.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_timing (
    input  logic               clk,
    input  logic               reset_n,
    input  vid_pkg::vid_cfg_t  cfg,
    output logic               pix_en,
    output vid_pkg::sync_t     sync,
    output vid_pkg::line_req_t line_req,
    output logic               flush
);

    import vid_pkg::*;

    logic [`VID_PCNT_WIDTH-1:0] div;
    logic                       tick;     // One clock per pixel
    logic [`VID_TWIDTH-1:0]     h;
    logic [`VID_TWIDTH-1:0]     v;
    logic [`VID_TWIDTH-1:0]     h_nxt;
    logic [`VID_TWIDTH-1:0]     v_nxt;
    logic [`VID_TWIDTH-1:0]     v_line;   // Line after the current one
    logic                       h_wrap;
    logic                       next_vis;

    assign tick     = cfg.en && (div >= cfg.pcnt);
    assign h_wrap   = (h + 1'b1) >= cfg.hend;
    assign h_nxt    = h_wrap ? '0 : h + 1'b1;
    assign v_line   = ((v + 1'b1) >= cfg.vend) ? '0 : v + 1'b1;
    assign v_nxt    = h_wrap ? v_line : v;
    assign next_vis = v_line < cfg.vsize;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div      <= '0;
            h        <= '0;
            v        <= '0;
            sync     <= SYNC_IDLE;
            pix_en   <= 1'b0;
            line_req <= '0;
            flush    <= 1'b0;
        end else begin
            pix_en   <= tick;                 // Marks the first clock of a pixel
            line_req <= '0;
            flush    <= 1'b0;
            if (!cfg.en) begin
                // Park just before blanking of the last line so line 0 is fetched first
                div  <= '0;
                h    <= cfg.hsize - 1'b1;
                v    <= cfg.vend - 1'b1;
                sync <= SYNC_IDLE;
            end else begin
                div <= tick ? '0 : div + 1'b1;
                if (tick) begin
                    h    <= h_nxt;
                    v    <= v_nxt;
                    sync <= '{hsync:  (h_nxt >= cfg.hsync_start) && (h_nxt < cfg.hsync_end),
                              hblank: h_nxt >= cfg.hsize,
                              vsync:  (v_nxt >= cfg.vsync_start) && (v_nxt < cfg.vsync_end),
                              vblank: v_nxt >= cfg.vsize};
                    if (h_nxt == cfg.hsize) begin
                        flush <= 1'b1;        // Drop leftovers of the finished line
                        if (next_vis) begin
                            line_req <= '{start: 1'b1, line: v_line};
                        end
                    end
                end
            end
        end
    end

    // Blanking covers every count past the visible width
    a_hblank_tail: assert property (@(posedge clk) disable iff (!reset_n)
        (cfg.en && (h >= cfg.hsize)) |-> (sync.hsync || sync.hblank));

endmodule
